//--- flist.f
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/mips_core.sv
verification/mips_core_properties.sv
verification/tb_mips_core.sv

//--- hw/decode_stage.sv
module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     if_instr,
    input  word_t     if_pc_next,
    input  logic      if_valid,
    input  logic      branch_taken,
    input  logic      mem_busy,
    input  logic      wb_reg_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      hazard_stall,
    output logic      id_valid,
    output alu_op_e   id_alu_op,
    output logic      id_use_imm,
    output word_t     id_imm,
    output reg_addr_t id_rs,
    output reg_addr_t id_rt,
    output reg_addr_t id_rd,
    output word_t     id_rs_data,
    output word_t     id_rt_data,
    output logic      id_reg_we,
    output logic      id_mem_re,
    output logic      id_mem_we,
    output logic      id_branch,
    output logic      id_branch_ne,
    output word_t     id_pc_next
);

opcode_e          opcode;
funct_e           funct;
reg_addr_t        rs;
reg_addr_t        rt;
reg_addr_t        rd;
logic [IMM_W-1:0] imm;
word_t            imm_ext;
alu_op_e          dec_alu_op;
logic             dec_reg_we;
logic             dec_sign_ext;
logic             reads_rs;
logic             reads_rt;
logic             load_bubble;
word_t            rs_data;
word_t            rt_data;
word_t            regs [2**REG_ADDR_W];

//////////////////////////////
// Decoder
//////////////////////////////

assign opcode = opcode_e'(if_instr[OPCODE_LSB +: $bits(opcode_e)]);
assign funct  = funct_e'(if_instr[FUNCT_LSB +: $bits(funct_e)]);
assign rs     = if_instr[RS_LSB +: REG_ADDR_W];
assign rt     = if_instr[RT_LSB +: REG_ADDR_W];
assign rd     = if_instr[RD_LSB +: REG_ADDR_W];
assign imm    = if_instr[IMM_W-1:0];

// ANDI and ORI take a zero-extended immediate
assign dec_sign_ext = !(opcode == OP_ANDI || opcode == OP_ORI);
assign imm_ext = dec_sign_ext ? {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm}
                              : {{(XLEN-IMM_W){1'b0}}, imm};

assign reads_rs = (opcode != OP_LUI);
assign reads_rt = (opcode == OP_RTYPE) || (opcode == OP_SW)
               || (opcode == OP_BEQ) || (opcode == OP_BNE);

always_comb begin
    dec_alu_op = ALU_ADD;
    dec_reg_we = 1'b1;
    case (opcode)
        OP_RTYPE: begin
            case (funct)
                FN_ADD:  dec_alu_op = ALU_ADD;
                FN_SUB:  dec_alu_op = ALU_SUB;
                FN_AND:  dec_alu_op = ALU_AND;
                FN_OR:   dec_alu_op = ALU_OR;
                FN_XOR:  dec_alu_op = ALU_XOR;
                FN_SLT:  dec_alu_op = ALU_SLT;
                default: dec_reg_we = 1'b0;
            endcase
        end
        OP_ADDI, OP_LW: dec_alu_op = ALU_ADD;
        OP_ANDI:        dec_alu_op = ALU_AND;
        OP_ORI:         dec_alu_op = ALU_OR;
        OP_LUI:         dec_alu_op = ALU_LUI;
        // SW, branches and unknown opcodes write nothing
        default:        dec_reg_we = 1'b0;
    endcase
end

//////////////////////////////
// Register file
//////////////////////////////

// Write-back in the same cycle is seen by the read
assign rs_data = (rs == '0) ? '0 : (wb_reg_we && wb_rd == rs) ? wb_data : regs[rs];
assign rt_data = (rt == '0) ? '0 : (wb_reg_we && wb_rd == rt) ? wb_data : regs[rt];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_reg_we) begin
        regs[wb_rd] <= wb_data;
    end
end

// Load in EX feeding the instruction in decode
assign hazard_stall = if_valid && id_valid && id_mem_re && (id_rd != '0)
                   && ((reads_rs && id_rd == rs) || (reads_rt && id_rd == rt));

assign load_bubble = branch_taken || hazard_stall || !if_valid;

//////////////////////////////
// ID/EX register
//////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        id_valid  <= 1'b0;
        id_reg_we <= 1'b0;
        id_mem_re <= 1'b0;
        id_mem_we <= 1'b0;
        id_branch <= 1'b0;
    end else if (!mem_busy) begin
        id_valid  <= !load_bubble;
        id_reg_we <= !load_bubble && dec_reg_we;
        id_mem_re <= !load_bubble && (opcode == OP_LW);
        id_mem_we <= !load_bubble && (opcode == OP_SW);
        id_branch <= !load_bubble && (opcode == OP_BEQ || opcode == OP_BNE);
    end
end

always_ff @(posedge clk) begin
    if (!mem_busy) begin
        id_alu_op    <= dec_alu_op;
        id_use_imm   <= !(opcode == OP_RTYPE || opcode == OP_BEQ || opcode == OP_BNE);
        id_imm       <= imm_ext;
        id_rs        <= rs;
        id_rt        <= rt;
        id_rd        <= (opcode == OP_RTYPE) ? rd : rt;
        id_rs_data   <= rs_data;
        id_rt_data   <= rt_data;
        id_branch_ne <= (opcode == OP_BNE);
        id_pc_next   <= if_pc_next;
    end
end

endmodule

//--- hw/execute_stage.sv
module execute_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_busy,
    input  logic      id_valid,
    input  alu_op_e   id_alu_op,
    input  logic      id_use_imm,
    input  word_t     id_imm,
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  reg_addr_t id_rd,
    input  word_t     id_rs_data,
    input  word_t     id_rt_data,
    input  logic      id_reg_we,
    input  logic      id_mem_re,
    input  logic      id_mem_we,
    input  logic      id_branch,
    input  logic      id_branch_ne,
    input  word_t     id_pc_next,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_we,
    input  word_t     mem_result,
    input  logic      wb_reg_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      branch_taken,
    output word_t     branch_target,
    output logic      ex_valid,
    output word_t     ex_result,
    output word_t     ex_store_data,
    output reg_addr_t ex_rd,
    output logic      ex_reg_we,
    output logic      ex_mem_re,
    output logic      ex_mem_we
);

fwd_sel_e rs_sel;
fwd_sel_e rt_sel;
word_t    op_a;
word_t    op_rt;
word_t    op_b;
word_t    alu_out;

// Youngest producer wins, r0 is never forwarded
function automatic fwd_sel_e pick_source(input reg_addr_t src, input reg_addr_t mem_dst,
                                         input logic mem_wr, input reg_addr_t wb_dst,
                                         input logic wb_wr);
    if (src == '0) begin
        return FWD_NONE;
    end else if (mem_wr && mem_dst == src) begin
        return FWD_MEM;
    end else if (wb_wr && wb_dst == src) begin
        return FWD_WB;
    end
    return FWD_NONE;
endfunction

function automatic word_t forward_value(input fwd_sel_e sel, input word_t reg_val,
                                        input word_t mem_val, input word_t wb_val);
    case (sel)
        FWD_MEM: return mem_val;
        FWD_WB:  return wb_val;
        default: return reg_val;
    endcase
endfunction

assign rs_sel = pick_source(id_rs, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
assign rt_sel = pick_source(id_rt, mem_rd, mem_reg_we, wb_rd, wb_reg_we);
assign op_a   = forward_value(rs_sel, id_rs_data, mem_result, wb_data);
assign op_rt  = forward_value(rt_sel, id_rt_data, mem_result, wb_data);
assign op_b   = id_use_imm ? id_imm : op_rt;

always_comb begin
    case (id_alu_op)
        ALU_ADD: alu_out = op_a + op_b;
        ALU_SUB: alu_out = op_a - op_b;
        ALU_AND: alu_out = op_a & op_b;
        ALU_OR:  alu_out = op_a | op_b;
        ALU_XOR: alu_out = op_a ^ op_b;
        ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
        ALU_LUI: alu_out = {op_b[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
        default: alu_out = op_a + op_b;
    endcase
end

// BEQ and BNE compare the forwarded registers
assign branch_taken  = id_valid && id_branch && ((op_a == op_rt) != id_branch_ne);
assign branch_target = id_pc_next + (id_imm << 2);

//////////////////////////////
// EX/MEM register
//////////////////////////////

always_ff @(posedge clk) begin
    if (rst) begin
        ex_valid  <= 1'b0;
        ex_reg_we <= 1'b0;
        ex_mem_re <= 1'b0;
        ex_mem_we <= 1'b0;
    end else if (!mem_busy) begin
        ex_valid  <= id_valid;
        ex_reg_we <= id_reg_we;
        ex_mem_re <= id_mem_re;
        ex_mem_we <= id_mem_we;
    end
end

always_ff @(posedge clk) begin
    if (!mem_busy) begin
        ex_result     <= alu_out;
        ex_store_data <= op_rt;
        ex_rd         <= id_rd;
    end
end

endmodule

//--- hw/fetch_stage.sv
module fetch_stage import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t imem_data,
    input  logic  hazard_stall,
    input  logic  mem_busy,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t imem_addr,
    output word_t if_instr,
    output word_t if_pc_next,
    output logic  if_valid
);

word_t pc;
word_t pc_plus_step;

assign pc_plus_step = pc + PC_STEP;
assign imem_addr    = pc;

// Not-taken prediction, a resolved branch overrides the load-use stall
always_ff @(posedge clk) begin
    if (rst) begin
        pc <= RESET_PC;
    end else if (!mem_busy) begin
        if (branch_taken) begin
            pc <= branch_target;
        end else if (!hazard_stall) begin
            pc <= pc_plus_step;
        end
    end
end

// IF/ID valid bit
always_ff @(posedge clk) begin
    if (rst) begin
        if_valid <= 1'b0;
    end else if (!mem_busy) begin
        if (branch_taken) begin
            if_valid <= 1'b0;
        end else if (!hazard_stall) begin
            if_valid <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (!mem_busy && !hazard_stall) begin
        if_instr   <= imem_data;
        if_pc_next <= pc_plus_step;
    end
end

endmodule

//--- hw/memory_stage.sv
module memory_stage import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      wb_dat_r,
    input  logic       wb_ack,
    input  logic       ex_valid,
    input  word_t      ex_result,
    input  word_t      ex_store_data,
    input  reg_addr_t  ex_rd,
    input  logic       ex_reg_we,
    input  logic       ex_mem_re,
    input  logic       ex_mem_we,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output word_t      wb_dat_w,
    output logic [3:0] wb_sel,
    output logic       mem_busy,
    output reg_addr_t  mem_rd,
    output logic       mem_reg_we,
    output word_t      mem_result,
    output reg_addr_t  wb_rd,
    output logic       wb_reg_we,
    output word_t      wb_data,
    output logic       commit_valid,
    output reg_addr_t  commit_rd,
    output word_t      commit_data
);

typedef enum logic {
    BUS_IDLE,
    BUS_BUSY
} bus_state_e;

bus_state_e state;
logic       access;
logic       wb_fresh;

//////////////////////////////
// Wishbone master
//////////////////////////////

assign access   = ex_valid && (ex_mem_re || ex_mem_we);
// Whole pipeline waits from the first MEM cycle of an access until ack
assign mem_busy = access && !(state == BUS_BUSY && wb_ack);

always_ff @(posedge clk) begin
    if (rst) begin
        state <= BUS_IDLE;
    end else begin
        case (state)
            BUS_IDLE: if (access) state <= BUS_BUSY;
            BUS_BUSY: if (wb_ack) state <= BUS_IDLE;
            default:  state <= BUS_IDLE;
        endcase
    end
end

// Address and data come from the frozen EX/MEM register
assign wb_cyc   = (state == BUS_BUSY);
assign wb_stb   = (state == BUS_BUSY);
assign wb_we    = ex_mem_we;
assign wb_adr   = ex_result;
assign wb_dat_w = ex_store_data;
assign wb_sel   = 4'hf;

// Loads have no value to forward until write-back
assign mem_rd     = ex_rd;
assign mem_reg_we = ex_reg_we && !ex_mem_re;
assign mem_result = ex_result;

//////////////////////////////
// MEM/WB register
//////////////////////////////

// The fresh flag marks the first cycle of an instruction in WB
always_ff @(posedge clk) begin
    if (rst) begin
        wb_reg_we <= 1'b0;
        wb_fresh  <= 1'b0;
    end else if (mem_busy) begin
        wb_fresh  <= 1'b0;
    end else begin
        wb_reg_we <= ex_reg_we && (ex_rd != '0);
        wb_fresh  <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (!mem_busy) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_mem_re ? wb_dat_r : ex_result;
    end
end

assign commit_valid = wb_reg_we && wb_fresh;
assign commit_rd    = wb_rd;
assign commit_data  = wb_data;

endmodule

//--- hw/mips_core.sv
module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // Instruction port
    output word_t       imem_addr,
    input  word_t       imem_data,
    // Wishbone data port
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output word_t       wb_adr,
    output word_t       wb_dat_w,
    output logic [3:0]  wb_sel,
    input  word_t       wb_dat_r,
    input  logic        wb_ack,
    // Retired register writes
    output logic        commit_valid,
    output reg_addr_t   commit_rd,
    output word_t       commit_data
);

//////////////////////////////
// Stage to stage wires
//////////////////////////////

// IF/ID
word_t     if_instr;
word_t     if_pc_next;
logic      if_valid;

// Stall, flush and freeze
logic      hazard_stall;
logic      mem_busy;
logic      branch_taken;
word_t     branch_target;

// ID/EX
logic      id_valid;
alu_op_e   id_alu_op;
logic      id_use_imm;
word_t     id_imm;
reg_addr_t id_rs;
reg_addr_t id_rt;
reg_addr_t id_rd;
word_t     id_rs_data;
word_t     id_rt_data;
logic      id_reg_we;
logic      id_mem_re;
logic      id_mem_we;
logic      id_branch;
logic      id_branch_ne;
word_t     id_pc_next;

// EX/MEM
logic      ex_valid;
word_t     ex_result;
word_t     ex_store_data;
reg_addr_t ex_rd;
logic      ex_reg_we;
logic      ex_mem_re;
logic      ex_mem_we;

// Forwarding sources and register file write
reg_addr_t mem_rd;
logic      mem_reg_we;
word_t     mem_result;
reg_addr_t wb_rd;
logic      wb_reg_we;
word_t     wb_data;

//////////////////////////////
// Stages
//////////////////////////////

fetch_stage fetch_i (.*);

decode_stage decode_i (.*);

execute_stage execute_i (.*);

memory_stage memory_i (.*);

endmodule

//--- hw/mips_pkg.sv
package mips_pkg;

//////////////////////////////
// Widths and word types
//////////////////////////////

localparam int XLEN       = 32;
localparam int REG_ADDR_W = 5;

typedef logic [XLEN-1:0]       word_t;
typedef logic [REG_ADDR_W-1:0] reg_addr_t;

// Instruction field positions
localparam int OPCODE_LSB = 26;
localparam int RS_LSB     = 21;
localparam int RT_LSB     = 16;
localparam int RD_LSB     = 11;
localparam int FUNCT_LSB  = 0;
localparam int IMM_W      = 16;

// Program counter
localparam word_t PC_STEP  = word_t'(4);
localparam word_t RESET_PC = '0;

//////////////////////////////
// Encodings
//////////////////////////////

// Primary opcode, standard MIPS values
typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
} opcode_e;

// R-type function field
typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_XOR = 6'h26,
    FN_SLT = 6'h2a
} funct_e;

typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_LUI
} alu_op_e;

// Operand source in execute
typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
} fwd_sel_e;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_mips_core -f flist.f -o sim_mips

# The simulator exits non-zero on a failed run, the log decides
./obj_dir/sim_mips > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log

//--- verification/mips_core_properties.sv
module mips_core_properties import mips_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      wb_we,
    input word_t     wb_adr,
    input word_t     wb_dat_w,
    input logic      wb_ack,
    input logic      commit_valid,
    input reg_addr_t commit_rd
);

timeunit 1ns;
timeprecision 1ps;

//////////////////////////////
// Wishbone classic
//////////////////////////////

stb_matches_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb == wb_cyc)
    else $error("wb_stb differs from wb_cyc");

// Master holds the request until ack
request_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
    else $error("bus request changed before ack");

//////////////////////////////
// Commit port
//////////////////////////////

no_commit_to_r0: assert property (@(posedge clk) disable iff (rst)
    commit_valid |-> (commit_rd != '0))
    else $error("commit to register zero");

idle_after_reset: assert property (@(posedge clk) rst |=> (!wb_cyc && !commit_valid))
    else $error("bus or commit active right after reset");

endmodule

//--- verification/tb_mips_core.sv
module tb_mips_core import mips_pkg::*; ();

timeunit 1ns;
timeprecision 1ps;

localparam int    PROG_LEN        = 200;
localparam int    LOOP_IDX        = PROG_LEN - 1;
localparam word_t LOOP_ADDR       = word_t'(LOOP_IDX * 4);
localparam int    DMEM_WORDS      = 64;
localparam int    WATCHDOG_CYCLES = (PROG_LEN + 20) * 12;

logic        clk = 1'b0;
logic        rst;
word_t       imem_addr;
word_t       imem_data;
logic        wb_cyc;
logic        wb_stb;
logic        wb_we;
word_t       wb_adr;
word_t       wb_dat_w;
logic [3:0]  wb_sel;
word_t       wb_dat_r;
logic        wb_ack;
logic        commit_valid;
reg_addr_t   commit_rd;
word_t       commit_data;

logic [31:0] seed = 32'h622d57fe;
word_t       rom [256];
word_t       dmem [DMEM_WORDS];
word_t       model_regs [32];
word_t       model_mem [DMEM_WORDS];
reg_addr_t   exp_rd [$];
word_t       exp_data [$];
word_t       exp_st_adr [$];
word_t       exp_st_dat [$];
int          exp_commits;
int          exp_stores;
int          commit_count = 0;
int          store_count = 0;
int          errors = 0;
int          loop_hits = 0;
word_t       last_addr = '0;
logic        pending = 1'b0;
int          ack_wait = 0;

always #20 clk = ~clk;

mips_core dut_i (.*);

bind mips_core mips_core_properties props_i (
    .clk          (clk),
    .rst          (rst),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_ack       (wb_ack),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd)
);

// Combinational instruction ROM with nops past the end
assign imem_data = (imem_addr < word_t'(PROG_LEN * 4)) ? rom[imem_addr[9:2]] : '0;

//////////////////////////////
// Helpers
//////////////////////////////

function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

function automatic int pick(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'((r >> 8) % n);
endfunction

function automatic word_t r_type(input funct_e fn, input int rd, input int rs, input int rt);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t i_type(input opcode_e op, input int rs, input int rt,
                                 input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

// Initial memory contents derived from the byte address
function automatic word_t fill_word(input int idx);
    word_t addr;
    addr = word_t'(idx * 4);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]};
endfunction

task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
endtask

task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
        errors++;
        fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
endtask

//////////////////////////////
// Program and model
//////////////////////////////

task automatic build_program();
    int     kind;
    int     off;
    int     a;
    int     b;
    funct_e fn;
    for (int i = 0; i < 256; i++) begin
        rom[i] = '0;
    end
    for (int i = 0; i < LOOP_IDX; i++) begin
        kind = pick(16);
        if (kind < 6) begin
            case (kind)
                0:       fn = FN_ADD;
                1:       fn = FN_SUB;
                2:       fn = FN_AND;
                3:       fn = FN_OR;
                4:       fn = FN_XOR;
                default: fn = FN_SLT;
            endcase
            rom[i] = r_type(fn, pick(8), pick(8), pick(8));
        end else begin
            case (kind)
                6:       rom[i] = i_type(OP_ADDI, pick(8), pick(8), 16'(pick(65536)));
                7:       rom[i] = i_type(OP_ANDI, pick(8), pick(8), 16'(pick(65536)));
                8:       rom[i] = i_type(OP_ORI, pick(8), pick(8), 16'(pick(65536)));
                9:       rom[i] = i_type(OP_LUI, 0, pick(8), 16'(pick(65536)));
                10, 11:  rom[i] = i_type(OP_LW, 0, pick(8), 16'(pick(64) * 4));
                12, 13:  rom[i] = i_type(OP_SW, 0, pick(8), 16'(pick(64) * 4));
                default: begin
                    // Forward only and never past the final loop
                    off = pick(4) + 1;
                    if (i + 1 + off > LOOP_IDX) begin
                        off = LOOP_IDX - i - 1;
                    end
                    a = pick(8);
                    b = (pick(2) == 0) ? a : pick(8);
                    rom[i] = i_type((kind == 14) ? OP_BEQ : OP_BNE, a, b, 16'(off));
                end
            endcase
        end
    end
    rom[LOOP_IDX] = i_type(OP_BEQ, 0, 0, 16'hffff);
endtask

task automatic run_model();
    int        pc;
    int        next_pc;
    word_t     instr;
    opcode_e   op;
    word_t     a;
    word_t     b;
    word_t     sext;
    word_t     zext;
    word_t     res;
    word_t     addr;
    reg_addr_t dst;
    logic      wr;
    pc = 0;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    while (pc != LOOP_IDX) begin
        instr   = rom[pc];
        op      = opcode_e'(instr[31:26]);
        a       = model_regs[instr[25:21]];
        b       = model_regs[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        zext    = {16'h0000, instr[15:0]};
        next_pc = pc + 1;
        dst     = instr[20:16];
        wr      = 1'b1;
        res     = '0;
        case (op)
            OP_RTYPE: begin
                dst = instr[15:11];
                case (funct_e'(instr[5:0]))
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
            end
            OP_ADDI: res = a + sext;
            OP_ANDI: res = a & zext;
            OP_ORI:  res = a | zext;
            OP_LUI:  res = {instr[15:0], 16'h0000};
            OP_LW: begin
                addr = a + sext;
                res  = model_mem[addr[7:2]];
            end
            OP_SW: begin
                addr = a + sext;
                exp_st_adr.push_back(addr);
                exp_st_dat.push_back(b);
                model_mem[addr[7:2]] = b;
                wr = 1'b0;
            end
            default: begin
                wr = 1'b0;
                if ((a == b) == (op == OP_BEQ)) begin
                    next_pc = pc + 1 + int'($signed(sext));
                end
            end
        endcase
        if (wr && dst != '0) begin
            model_regs[dst] = res;
            exp_rd.push_back(dst);
            exp_data.push_back(res);
        end
        pc = next_pc;
    end
    exp_commits = exp_rd.size();
    exp_stores  = exp_st_adr.size();
endtask

//////////////////////////////
// Wishbone slave
//////////////////////////////

task automatic serve_access();
    check_value("bus select", word_t'(4'hf), word_t'(wb_sel));
    if (wb_adr[1:0] != 2'b00 || wb_adr >= word_t'(DMEM_WORDS * 4)) begin
        fail_run($sformatf("bus address %h lies outside the data memory", wb_adr));
    end else if (wb_we) begin
        if (exp_st_adr.size() == 0) begin
            fail_run("store seen after the last expected store");
        end else begin
            check_value($sformatf("store %0d address", store_count), exp_st_adr[0], wb_adr);
            check_value($sformatf("store %0d data", store_count), exp_st_dat[0], wb_dat_w);
            void'(exp_st_adr.pop_front());
            void'(exp_st_dat.pop_front());
            dmem[wb_adr[7:2]] = wb_dat_w;
            store_count++;
        end
    end else begin
        wb_dat_r = dmem[wb_adr[7:2]];
    end
endtask

// Random wait of 0 to 3 cycles before ack
always @(posedge clk) begin
    #2;
    if (wb_cyc && wb_stb && !wb_ack) begin
        if (!pending) begin
            pending  = 1'b1;
            ack_wait = pick(4);
        end
        if (ack_wait == 0) begin
            serve_access();
            wb_ack  = 1'b1;
            pending = 1'b0;
        end else begin
            ack_wait--;
        end
    end else begin
        wb_ack = 1'b0;
    end
end

//////////////////////////////
// Commit checker
//////////////////////////////

always @(negedge clk) begin
    if (!rst) begin
        if (commit_valid) begin
            if (exp_rd.size() == 0) begin
                fail_run("commit seen after the last expected commit");
            end else begin
                check_value($sformatf("commit %0d rd", commit_count),
                            word_t'(exp_rd[0]), word_t'(commit_rd));
                check_value($sformatf("commit %0d data", commit_count),
                            exp_data[0], commit_data);
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                commit_count++;
            end
        end
        // Each new arrival of the fetch PC at the final loop
        if (imem_addr == LOOP_ADDR && last_addr != LOOP_ADDR) begin
            loop_hits++;
        end
        last_addr = imem_addr;
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("timeout, the program never settled in its final loop");
end

initial begin
    rst      = 1'b1;
    wb_ack   = 1'b0;
    wb_dat_r = '0;
    for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i]      = fill_word(i);
        model_mem[i] = fill_word(i);
    end
    build_program();
    run_model();
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    while (loop_hits < 4) begin
        @(posedge clk);
    end
    // Let the last loads and stores drain
    repeat (20) @(posedge clk);
    check_value("commit count", word_t'(exp_commits), word_t'(commit_count));
    check_value("store count", word_t'(exp_stores), word_t'(store_count));
    if (errors == 0) begin
        $display("TESTS PASSED");
        $finish;
    end else begin
        fail_run("checks failed during the run");
    end
end

endmodule
